/* soc_periph.f */
+incdir+verif
source/soc_periph_bus_pkg.sv
source/soc_periph_gpio_pkg.sv
source/periph_apb_decode.sv
source/gpio_bank.sv
source/periph_return_path.sv
source/soc_periph_top.sv
verif/tb_soc_periph.sv

/* verif/tb_soc_periph_seq.svh */
// APB transfer tasks and the stimulus sequence of the peripheral testbench
// included inside the testbench module where it drives on falling edges and updates the model
`ifndef TB_SOC_PERIPH_SEQ_SVH
`define TB_SOC_PERIPH_SEQ_SVH

// random upper address bits that the decoder must ignore
function automatic logic [APB_ADDR_WIDTH-1:0] make_addr(input int slot, input logic [7:0] off);
  logic [APB_ADDR_WIDTH-1:0] a;
  a = $urandom();
  a[SLOT_LSB +: SLOT_WIDTH] = SLOT_WIDTH'(slot);
  a[7:0] = off;
  return a;
endfunction

task automatic bus_xfer(input logic wr, input int slot, input logic [7:0] off,
                        input logic [31:0] wdata, input logic [31:0] exp_rd, input logic exp_err);
  int cycles;
  @(negedge clk);
  apb_req.paddr   = make_addr(slot, off);
  apb_req.pwdata  = wdata;
  apb_req.pwrite  = wr;
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;  // setup phase
  @(negedge clk);
  apb_req.penable = 1'b1;
  exp_prdata  = wr ? '0 : exp_rd;  // banks return 0 on writes
  exp_pslverr = exp_err;
  rsp_check   = 1'b1;
  cycles      = 0;
  do begin
    @(posedge clk);
    cycles++;
    if (cycles > TIMEOUT) abort_on_timeout("pready in the APB access phase");
  end while (!apb_rsp.pready);
  @(negedge clk);
  apb_req   = '0;
  rsp_check = 1'b0;
endtask

task automatic write_reg(input int slot, input logic [7:0] off, input logic [31:0] d,
                         input logic err);
  bus_xfer(1'b1, slot, off, d, '0, err);
endtask

task automatic read_reg(input int slot, input logic [7:0] off, input logic [31:0] exp,
                        input logic err);
  bus_xfer(1'b0, slot, off, $urandom(), exp, err);
endtask

task automatic wait_for_event(input int pos, input string what);
  int cycles;
  cycles = 0;
  while (!fc_events[pos]) begin
    @(negedge clk);
    cycles++;
    if (cycles > TIMEOUT) abort_on_timeout(what);
  end
endtask

////////////////////////////////////////
// behaviors
////////////////////////////////////////
task automatic reset_values();
  repeat (3) @(negedge clk);  // idle while the assertions watch the outputs
  for (int k = 0; k < N_BANKS; k++) read_reg(k, GPIO_DIR, '0, 1'b0);
endtask

task automatic regs_readback();
  logic [31:0] dir;
  logic [31:0] out;
  for (int k = 0; k < N_BANKS; k++) begin
    dir = $urandom();
    out = $urandom();
    write_reg(k, GPIO_DIR, dir, 1'b0);
    exp_oe[k*BANK_WIDTH +: BANK_WIDTH] = dir[BANK_WIDTH-1:0];
    write_reg(k, GPIO_OUT, out, 1'b0);
    exp_out[k*BANK_WIDTH +: BANK_WIDTH] = out[BANK_WIDTH-1:0];
    read_reg(k, GPIO_DIR, 32'(dir[BANK_WIDTH-1:0]), 1'b0);
    read_reg(k, GPIO_OUT, 32'(out[BANK_WIDTH-1:0]), 1'b0);
    write_reg(k, GPIO_IN, $urandom(), 1'b0);  // read only
    read_reg(k, GPIO_IN, '0, 1'b0);
    read_reg(k, GPIO_INTEN, '0, 1'b0);  // no other register took the write
  end
endtask

task automatic input_sampling();
  logic [PW-1:0] pins;
  pins = PW'($urandom());
  @(negedge clk);
  gpio_in = pins;
  repeat (2) @(negedge clk);  // first access phase samples after the 4th rising edge
  for (int k = 0; k < N_BANKS; k++) begin
    read_reg(k, GPIO_IN, 32'(pins[k*BANK_WIDTH +: BANK_WIDTH]), 1'b0);
    // every set pin rose from 0
    read_reg(k, GPIO_INTSTAT, 32'(pins[k*BANK_WIDTH +: BANK_WIDTH]), 1'b0);
  end
  gpio_in = '0;
  repeat (5) @(negedge clk);
endtask

task automatic irq_flow();
  logic [BANK_WIDTH-1:0] en;
  logic [BANK_WIDTH-1:0] dis;
  for (int k = 0; k < N_BANKS; k++) begin
    en  = BANK_WIDTH'($urandom_range(1, 255));
    dis = ~en;
    write_reg(k, GPIO_INTEN, 32'(en), 1'b0);
    read_reg(k, GPIO_INTEN, 32'(en), 1'b0);
    irq_known = 1'b0;  // edge in flight
    gpio_in[k*BANK_WIDTH +: BANK_WIDTH] = en;
    wait_for_event(EVT_GPIO_BASE + k, $sformatf("bank %0d interrupt on fc_events_o", k));
    exp_irq[k] = 1'b1;
    irq_known  = 1'b1;
    read_reg(k, GPIO_INTSTAT, 32'(en), 1'b0);
    exp_irq[k] = 1'b0;  // cleared by that read
    read_reg(k, GPIO_INTSTAT, '0, 1'b0);
    gpio_in[k*BANK_WIDTH +: BANK_WIDTH] = '1;  // disabled pins rise and irq stays low
    repeat (5) @(negedge clk);
    read_reg(k, GPIO_INTSTAT, 32'(dis), 1'b0);
    read_reg(k, GPIO_INTSTAT, '0, 1'b0);
    gpio_in[k*BANK_WIDTH +: BANK_WIDTH] = '0;
    repeat (5) @(negedge clk);
  end
endtask

task automatic bus_errors();
  logic [7:0] off;
  int         slot;
  slot = $urandom_range(N_BANKS, 15);
  write_reg(slot, GPIO_DIR, $urandom(), 1'b1);  // no bank behind this slot
  read_reg(slot, GPIO_OUT, '0, 1'b1);
  for (int k = 0; k < N_BANKS; k++) begin
    off = 8'(8'h14 + $urandom_range(0, 8'hEB));  // past the last register
    write_reg(k, off, $urandom(), 1'b1);
    read_reg(k, off, '0, 1'b1);
    read_reg(k, GPIO_DIR, 32'(exp_oe[k*BANK_WIDTH +: BANK_WIDTH]), 1'b0);
    read_reg(k, GPIO_OUT, 32'(exp_out[k*BANK_WIDTH +: BANK_WIDTH]), 1'b0);
  end
endtask

task automatic ref_pulses();
  int n;
  int hold;
  n = $urandom_range(3, 10);
  @(negedge clk);
  for (int i = 0; i < n; i++) begin
    ref_clk = ~ref_clk;
    if (ref_clk) exp_rise++;
    else exp_fall++;
    hold = $urandom_range(5, 9);  // longer than the sync latency
    repeat (hold) @(negedge clk);
  end
  cnt_check = 1'b1;
  @(negedge clk);
  cnt_check = 1'b0;
endtask

task automatic run_sequence();
  reset_values();
  regs_readback();
  input_sampling();
  irq_flow();
  bus_errors();
  ref_pulses();
  repeat (2) @(negedge clk);
endtask

`endif

/* verif/tb_soc_periph.sv */
// testbench for the peripheral block with 4 GPIO banks
// concurrent assertions compare the DUT against model state kept by the stimulus
// APB tasks and the test sequence come from the included header
`timescale 1ns/10ps

module tb_soc_periph
  import soc_periph_bus_pkg::*;
  import soc_periph_gpio_pkg::*;
();

  localparam int N_BANKS = 4;
  localparam int TIMEOUT = 20;  // cycles, per wait loop
  localparam int PW      = N_BANKS * BANK_WIDTH;
  // event bits that may ever be high
  localparam logic [EVENT_WIDTH-1:0] EVT_USED = (EVENT_WIDTH'(1) << EVT_REF_RISE)
    | (EVENT_WIDTH'(1) << EVT_REF_FALL) | (EVENT_WIDTH'((1 << N_BANKS) - 1) << EVT_GPIO_BASE);

  logic                   clk;
  logic                   rst_n;
  logic                   ref_clk;
  apb_req_t               apb_req;
  apb_rsp_t               apb_rsp;
  logic [PW-1:0]          gpio_in;
  logic [PW-1:0]          gpio_out;
  logic [PW-1:0]          gpio_oe;
  logic [EVENT_WIDTH-1:0] fc_events;

  // model state, written on falling edges only
  logic [PW-1:0]             exp_oe;
  logic [PW-1:0]             exp_out;
  logic [N_BANKS-1:0]        exp_irq;
  logic                      irq_known;    // 0 while an edge is in flight
  logic                      rsp_check;    // high during the access phase
  logic [APB_DATA_WIDTH-1:0] exp_prdata;
  logic                      exp_pslverr;
  logic                      cnt_check;
  int                        rise_cnt = 0;
  int                        fall_cnt = 0;
  int                        exp_rise = 0;
  int                        exp_fall = 0;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns
  end

  soc_periph_top #(
    .N_BANKS     (N_BANKS)
  ) UUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .ref_clk_i   (ref_clk),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .gpio_in_i   (gpio_in),
    .gpio_out_o  (gpio_out),
    .gpio_oe_o   (gpio_oe),
    .fc_events_o (fc_events)
  );

  // ref pulses only move on rising edges, so count mid-cycle
  always @(negedge clk) begin
    if (rst_n && fc_events[EVT_REF_RISE]) rise_cnt++;
    if (rst_n && fc_events[EVT_REF_FALL]) fall_cnt++;
  end

  task automatic flag_mismatch(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
    $display("Test FAILED");
    $fatal(1, "stopped on timeout");
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  a_oe: assert property (@(posedge clk) disable iff (!rst_n) gpio_oe == exp_oe)
    else flag_mismatch("gpio_oe_o", exp_oe, $sampled(gpio_oe));
  a_out: assert property (@(posedge clk) disable iff (!rst_n) gpio_out == exp_out)
    else flag_mismatch("gpio_out_o", exp_out, $sampled(gpio_out));
  a_evt_unused: assert property (@(posedge clk) disable iff (!rst_n)
    (fc_events & ~EVT_USED) == '0)
    else flag_mismatch("fc_events_o unused bits", '0, $sampled(fc_events & ~EVT_USED));
  a_irq: assert property (@(posedge clk) disable iff (!rst_n)
    irq_known |-> fc_events[EVT_GPIO_BASE +: N_BANKS] == exp_irq)
    else flag_mismatch("fc_events_o gpio bits", exp_irq,
                       $sampled(fc_events[EVT_GPIO_BASE +: N_BANKS]));
  a_prdata: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_check |-> apb_rsp.prdata == exp_prdata)
    else flag_mismatch("apb_rsp_o.prdata", exp_prdata, $sampled(apb_rsp.prdata));
  a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_check |-> apb_rsp.pslverr == exp_pslverr)
    else flag_mismatch("apb_rsp_o.pslverr", exp_pslverr, $sampled(apb_rsp.pslverr));
  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !apb_req.psel |-> {apb_rsp.prdata, apb_rsp.pslverr} == '0)
    else flag_mismatch("apb_rsp_o idle {prdata,pslverr}", '0,
                       $sampled({apb_rsp.prdata, apb_rsp.pslverr}));
  a_rise_cnt: assert property (@(posedge clk) cnt_check |-> rise_cnt == exp_rise)
    else flag_mismatch("ref rise pulse count", exp_rise, rise_cnt);
  a_fall_cnt: assert property (@(posedge clk) cnt_check |-> fall_cnt == exp_fall)
    else flag_mismatch("ref fall pulse count", exp_fall, fall_cnt);

  `include "tb_soc_periph_seq.svh"

  initial begin
    void'($urandom(44191));
    rst_n       = 1'b0;
    ref_clk     = 1'b0;
    apb_req     = '0;
    gpio_in     = '0;
    exp_oe      = '0;
    exp_out     = '0;
    exp_irq     = '0;
    irq_known   = 1'b1;
    rsp_check   = 1'b0;
    exp_prdata  = '0;
    exp_pslverr = 1'b0;
    cnt_check   = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    run_sequence();
    $display("Test OK");
    $finish;
  end

endmodule

/* source/soc_periph_top.sv */
// peripheral block top level
// one APB slave port split over N_BANKS GPIO banks, responses merged back,
// bank irqs and ref clock edges driven onto the fc event vector
`timescale 1ns/10ps

module soc_periph_top
  import soc_periph_bus_pkg::*;
  import soc_periph_gpio_pkg::*;
#(
  parameter int N_BANKS = 4  // 1 to 8
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            ref_clk_i,
  input  apb_req_t                        apb_req_i,
  output apb_rsp_t                        apb_rsp_o,
  input  logic [N_BANKS*BANK_WIDTH-1:0]   gpio_in_i,
  output logic [N_BANKS*BANK_WIDTH-1:0]   gpio_out_o,
  output logic [N_BANKS*BANK_WIDTH-1:0]   gpio_oe_o,
  output logic [EVENT_WIDTH-1:0]          fc_events_o
);

  logic      [N_BANKS-1:0] slot_sel;
  logic                    unmapped;
  apb_rsp_t  [N_BANKS-1:0] bank_rsp;
  logic      [N_BANKS-1:0] bank_irq;
  gpio_pad_t [N_BANKS-1:0] bank_pad;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////
  periph_apb_decode #(
    .N_BANKS    (N_BANKS)
  ) u_decode (
    .apb_req_i  (apb_req_i),
    .slot_sel_o (slot_sel),
    .unmapped_o (unmapped)
  );

  ////////////////////////////////////////
  // gpio banks
  ////////////////////////////////////////
  for (genvar g = 0; g < N_BANKS; g++) begin : g_bank
    gpio_bank u_bank (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .apb_req_i (apb_req_i),  // shared, sel_i qualifies
      .sel_i     (slot_sel[g]),
      .apb_rsp_o (bank_rsp[g]),
      .pin_in_i  (gpio_in_i[g*BANK_WIDTH +: BANK_WIDTH]),
      .pad_o     (bank_pad[g]),
      .irq_o     (bank_irq[g])
    );

    assign gpio_out_o[g*BANK_WIDTH +: BANK_WIDTH] = bank_pad[g].out;
    assign gpio_oe_o[g*BANK_WIDTH +: BANK_WIDTH]  = bank_pad[g].oe;
  end

  // merge and events
  periph_return_path #(
    .N_BANKS     (N_BANKS)
  ) u_return (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ref_clk_i   (ref_clk_i),
    .slot_sel_i  (slot_sel),
    .unmapped_i  (unmapped),
    .bank_rsp_i  (bank_rsp),
    .bank_irq_i  (bank_irq),
    .apb_rsp_o   (apb_rsp_o),
    .fc_events_o (fc_events_o)
  );

endmodule

/* source/periph_return_path.sv */
// response merge and fc event assembly
// picks the selected bank's APB response or an error for unmapped slots,
// packs bank irqs and the ref clock edge pulses into the event vector
`timescale 1ns/10ps

module periph_return_path
  import soc_periph_bus_pkg::*;
  import soc_periph_gpio_pkg::*;
#(
  parameter int N_BANKS = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         ref_clk_i,    // slow, async to clk_i
  input  logic       [N_BANKS-1:0]     slot_sel_i,
  input  logic                         unmapped_i,
  input  apb_rsp_t   [N_BANKS-1:0]     bank_rsp_i,
  input  logic       [N_BANKS-1:0]     bank_irq_i,
  output apb_rsp_t                     apb_rsp_o,
  output logic       [EVENT_WIDTH-1:0] fc_events_o
);

  logic [1:0] ref_sync_q;
  logic       ref_prev_q;
  logic       ref_rise;
  logic       ref_fall;

  ////////////////////////////////////////
  // response mux
  ////////////////////////////////////////
  always_comb begin
    apb_rsp_o.prdata  = '0;  // idle answer
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    for (int i = 0; i < N_BANKS; i++) begin
      if (slot_sel_i[i]) begin
        apb_rsp_o = bank_rsp_i[i];
      end
    end
    if (unmapped_i) begin
      apb_rsp_o.pslverr = 1'b1;  // no slave there, prdata stays 0
    end
  end

  ////////////////////////////////////////
  // ref clock edges
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ref_sync_q <= '0;
      ref_prev_q <= 1'b0;
    end else begin
      ref_sync_q <= {ref_sync_q[0], ref_clk_i};
      ref_prev_q <= ref_sync_q[1];
    end
  end

  assign ref_rise = ref_sync_q[1] & ~ref_prev_q;  // one clk_i cycle wide
  assign ref_fall = ~ref_sync_q[1] & ref_prev_q;

  // unused positions tie to 0
  always_comb begin
    fc_events_o                              = '0;
    fc_events_o[EVT_REF_RISE]                = ref_rise;
    fc_events_o[EVT_REF_FALL]                = ref_fall;
    fc_events_o[EVT_GPIO_BASE +: N_BANKS]    = bank_irq_i;
  end

  // pulses are exclusive and drop after one cycle
  a_ref_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (ref_rise || ref_fall) |-> !(ref_rise && ref_fall) ##1 !(ref_rise || ref_fall)
  ) else $error("ref clock pulse overlap or longer than one cycle");

endmodule

/* source/gpio_bank.sv */
// one GPIO bank on an APB slot
// dir / out / inten registers, 2-flop input sync, rising edge status
// irq_o stays high while an enabled status bit is set
`timescale 1ns/10ps

module gpio_bank
  import soc_periph_bus_pkg::*;
  import soc_periph_gpio_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  apb_req_t              apb_req_i,
  input  logic                  sel_i,      // one-hot bit from the decoder
  output apb_rsp_t              apb_rsp_o,
  input  logic [BANK_WIDTH-1:0] pin_in_i,
  output gpio_pad_t             pad_o,
  output logic                  irq_o
);

  logic [BANK_WIDTH-1:0]       dir_q;
  logic [BANK_WIDTH-1:0]       out_q;
  logic [BANK_WIDTH-1:0]       inten_q;
  logic [BANK_WIDTH-1:0]       stat_q;
  logic [1:0][BANK_WIDTH-1:0]  sync_q;     // [1] is the synchronized value
  logic [BANK_WIDTH-1:0]       prev_q;
  logic [BANK_WIDTH-1:0]       rise;
  gpio_reg_e                   reg_addr;
  logic                        access;
  logic                        wr_en;
  logic                        rd_en;
  logic                        addr_ok;
  logic [APB_DATA_WIDTH-1:0]   rdata;

  ////////////////////////////////////////
  // apb access decode
  ////////////////////////////////////////
  assign access   = sel_i && apb_req_i.psel && apb_req_i.penable;  // access phase only
  assign wr_en    = access && apb_req_i.pwrite;
  assign rd_en    = access && !apb_req_i.pwrite;
  assign reg_addr = gpio_reg_e'(apb_req_i.paddr[OFFSET_WIDTH-1:0]);

  always_comb begin
    rdata   = '0;
    addr_ok = 1'b1;
    case (reg_addr)
      GPIO_DIR:     rdata = APB_DATA_WIDTH'(dir_q);
      GPIO_OUT:     rdata = APB_DATA_WIDTH'(out_q);
      GPIO_IN:      rdata = APB_DATA_WIDTH'(sync_q[1]);
      GPIO_INTEN:   rdata = APB_DATA_WIDTH'(inten_q);
      GPIO_INTSTAT: rdata = APB_DATA_WIDTH'(stat_q);
      default:      addr_ok = 1'b0;  // hole in the map
    endcase
  end

  assign apb_rsp_o.prdata  = rd_en ? rdata : '0;
  assign apb_rsp_o.pready  = 1'b1;  // no wait states
  assign apb_rsp_o.pslverr = access && !addr_ok;

  // control registers, IN and INTSTAT are not writable
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q   <= '0;
      out_q   <= '0;
      inten_q <= '0;
    end else if (wr_en) begin
      case (reg_addr)
        GPIO_DIR:   dir_q   <= apb_req_i.pwdata[BANK_WIDTH-1:0];
        GPIO_OUT:   out_q   <= apb_req_i.pwdata[BANK_WIDTH-1:0];
        GPIO_INTEN: inten_q <= apb_req_i.pwdata[BANK_WIDTH-1:0];
        default: ;  // ignored
      endcase
    end
  end

  ////////////////////////////////////////
  // input sync and edge detect
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      sync_q[0] <= pin_in_i;
      sync_q[1] <= sync_q[0];
      prev_q    <= sync_q[1];
    end
  end

  assign rise = sync_q[1] & ~prev_q;

  // read clears, but a new edge in the same cycle still lands
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stat_q <= '0;
    end else begin
      stat_q <= ((rd_en && (reg_addr == GPIO_INTSTAT)) ? '0 : stat_q) | rise;
    end
  end

  assign irq_o     = |(stat_q & inten_q);
  assign pad_o.out = out_q;
  assign pad_o.oe  = dir_q;

  // a setup phase on this bank must be followed by a completing access phase
  a_setup_then_ready: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (sel_i && apb_req_i.psel && !apb_req_i.penable)
      |=> (sel_i && apb_req_i.psel && apb_req_i.penable && apb_rsp_o.pready)
  ) else $error("bank setup phase not followed by ready access phase");

endmodule

/* source/periph_apb_decode.sv */
// APB slot decoder
// turns the slot field of paddr into one-hot bank selects,
// flags selects that land on a slot with no bank behind it
`timescale 1ns/10ps

module periph_apb_decode
  import soc_periph_bus_pkg::*;
#(
  parameter int N_BANKS = 4  // 1 to 8
) (
  input  apb_req_t           apb_req_i,
  output logic [N_BANKS-1:0] slot_sel_o,
  output logic               unmapped_o
);

  logic [SLOT_WIDTH-1:0] slot;

  assign slot = apb_req_i.paddr[SLOT_LSB +: SLOT_WIDTH];  // upper bits don't care

  ////////////////////////////////////////
  // slot compare
  ////////////////////////////////////////
  always_comb begin
    slot_sel_o = '0;
    for (int i = 0; i < N_BANKS; i++) begin
      if (apb_req_i.psel && (slot == SLOT_WIDTH'(i))) begin
        slot_sel_o[i] = 1'b1;
      end
    end
  end

  // anything at or past N_BANKS answers with an error in the return path
  assign unmapped_o = apb_req_i.psel && (slot >= SLOT_WIDTH'(N_BANKS));

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  // return path muxes on slot_sel, so at most one bank may drive
  a_sel_onehot: assert final (
    $onehot0(slot_sel_o) && !(unmapped_o && (|slot_sel_o))
  ) else begin
    $error("slot select not one-hot or overlaps unmapped: sel=%h unmapped=%b",
           slot_sel_o, unmapped_o);
  end

endmodule

/* source/soc_periph_gpio_pkg.sv */
// GPIO bank definitions and the fabric-controller event map
// register offsets, pad struct and event vector positions

package soc_periph_gpio_pkg;

  localparam int BANK_WIDTH = 8;  // pins per bank

  // register offsets inside one bank slot
  typedef enum logic [7:0] {
    GPIO_DIR     = 8'h00,  // 1 = output enable
    GPIO_OUT     = 8'h04,
    GPIO_IN      = 8'h08,  // read only, synchronized pins
    GPIO_INTEN   = 8'h0C,
    GPIO_INTSTAT = 8'h10   // rising edge status, cleared on read
  } gpio_reg_e;

  // pad side of one bank
  typedef struct packed {
    logic [BANK_WIDTH-1:0] out;
    logic [BANK_WIDTH-1:0] oe;
  } gpio_pad_t;

  ////////////////////////////////////////
  // fc event vector
  ////////////////////////////////////////
  localparam int EVENT_WIDTH   = 32;
  localparam int EVT_REF_RISE  = 18;
  localparam int EVT_REF_FALL  = 19;
  localparam int EVT_GPIO_BASE = 21;  // bank k at 21 + k

endpackage

/* source/soc_periph_bus_pkg.sv */
// APB bus definitions for the peripheral block
// widths, slot address map and the request/response structs
// shared by the decoder, the GPIO banks and the return path

package soc_periph_bus_pkg;

  ////////////////////////////////////////
  // apb widths
  ////////////////////////////////////////
  localparam int APB_ADDR_WIDTH = 32;
  localparam int APB_DATA_WIDTH = 32;

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////
  // paddr[11:8] picks the slot, paddr[7:0] is the register offset
  localparam int SLOT_LSB     = 8;
  localparam int SLOT_WIDTH   = 4;
  localparam int OFFSET_WIDTH = 8;  // offset field, bits above the slot are ignored

  // master -> slave, 67 bits
  typedef struct packed {
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
  } apb_req_t;

  // slave -> master, 34 bits
  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;   // zero wait states, always 1
    logic                      pslverr;
  } apb_rsp_t;

endpackage
